// ==== logic/addrgen_pkg.sv ====
/*
  Shared types and constants of the vector address generator.
  Address, stride, element count, byte count and AXI field types,
  page and burst limits, and the controller state encoding.
*/
package addrgen_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned AddrWidth = 32;

  typedef logic [AddrWidth-1:0] addr_t;
  // Two's complement byte stride
  typedef logic [AddrWidth-1:0] stride_t;
  typedef logic [15:0]          vl_t;
  // Enough for a 16-bit vl of 8-byte elements
  typedef logic [18:0]          bytes_t;
  // AXI len holds beats minus one
  typedef logic [7:0]           beat_len_t;
  typedef logic [2:0]           size_t;
  // 0 to 3 encode 1, 2, 4 and 8 byte elements
  typedef logic [1:0]           sew_t;

  //////////////////////////////////////////////////////////////////////
  // Burst limits
  //////////////////////////////////////////////////////////////////////

  // 4 KiB pages
  localparam int unsigned PageBits      = 12;
  localparam int unsigned MaxBurstBeats = 256;

  //////////////////////////////////////////////////////////////////////
  // Controller FSM
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    IDLE,
    UNIT,
    STRIDED
  } ctrl_state_e;

endpackage

// ==== logic/burst_if.sv ====
/*
  Burst planning link between controller and planner.
  The controller asks with an address and a byte count, the
  planner answers with one page-bounded burst and what is left.
*/
`timescale 1ns/1ps

interface burst_if;
  import addrgen_pkg::*;

  addr_t     cur_addr;
  bytes_t    rem_bytes;
  addr_t     start_addr;
  beat_len_t beats;
  addr_t     next_addr;
  bytes_t    next_rem;

  modport ctrl (output cur_addr, rem_bytes, input start_addr, beats, next_addr, next_rem);
  modport planner (input cur_addr, rem_bytes, output start_addr, beats, next_addr, next_rem);

endinterface

// ==== logic/lsu_req_if.sv ====
/*
  Request queue link between controller and address queue.
  Carries the pushed entry one way and the queue status back.
*/
`timescale 1ns/1ps

interface lsu_req_if;
  import addrgen_pkg::*;

  logic      push;
  addr_t     addr;
  beat_len_t len;
  size_t     size;
  logic      is_load;
  logic      full;
  logic      empty;
  logic      head_is_load;

  modport ctrl (output push, addr, len, size, is_load, input full, empty, head_is_load);
  modport queue (input push, addr, len, size, is_load, output full, empty, head_is_load);

endinterface

// ==== logic/burst_planner.sv ====
/*
  Combinational burst planner.
  Aligns the address to the bus, limits the burst to the page end,
  to the maximum AXI length and to the bytes still needed.
*/
`timescale 1ns/1ps

module burst_planner #(
  parameter int unsigned BusBytesLog2 = 3
) (
  burst_if.planner burst
);
  import addrgen_pkg::*;

  localparam int unsigned BusBytes = 1 << BusBytesLog2;
  // One bit of headroom over the byte count for rounding up
  localparam int unsigned CntW     = $bits(bytes_t) + 1;

  addr_t                 start;
  logic [BusBytesLog2-1:0] cur_off;
  logic [PageBits:0]     page_bytes;
  logic [CntW-1:0]       page_beats;
  logic [CntW-1:0]       span_bytes;
  logic [CntW-1:0]       need_beats;
  logic [CntW-1:0]       sel_beats;
  logic [CntW-1:0]       covered;

  always_comb begin
    cur_off = burst.cur_addr[BusBytesLog2-1:0];
    start   = {burst.cur_addr[AddrWidth-1:BusBytesLog2], {BusBytesLog2{1'b0}}};

    // Beats left until the 4 KiB boundary
    page_bytes = (PageBits+1)'(1 << PageBits) - {1'b0, start[PageBits-1:0]};
    page_beats = CntW'(page_bytes >> BusBytesLog2);

    // Beats covering the misaligned head plus the remaining bytes, rounded up
    span_bytes = CntW'(burst.rem_bytes) + CntW'(cur_off) + CntW'(BusBytes - 1);
    need_beats = span_bytes >> BusBytesLog2;

    sel_beats = page_beats;
    if (CntW'(MaxBurstBeats) < sel_beats) begin
      sel_beats = CntW'(MaxBurstBeats);
    end
    if (need_beats < sel_beats) begin
      sel_beats = need_beats;
    end
    // An empty instruction still issues a single beat
    if (sel_beats == '0) begin
      sel_beats = CntW'(1);
    end

    // Bytes from cur_addr up to the end of this burst
    covered = (sel_beats << BusBytesLog2) - CntW'(cur_off);

    burst.start_addr = start;
    burst.beats      = beat_len_t'(sel_beats - CntW'(1));
    burst.next_addr  = start + addr_t'(sel_beats << BusBytesLog2);
    if (CntW'(burst.rem_bytes) > covered) begin
      burst.next_rem = bytes_t'(CntW'(burst.rem_bytes) - covered);
    end else begin
      burst.next_rem = '0;
    end
  end

endmodule

// ==== logic/addr_queue.sv ====
/*
  Queue of issued address requests for the load/store unit.
  Circular buffer with read and write pointers and a fill count,
  and the direction of the head entry for the issue rule.
*/
`timescale 1ns/1ps

module addr_queue #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  lsu_req_if.queue               lsu_req,
  output logic                   lsu_valid_o,
  input  logic                   lsu_ready_i,
  output addrgen_pkg::addr_t     lsu_addr_o,
  output addrgen_pkg::beat_len_t lsu_len_o,
  output addrgen_pkg::size_t     lsu_size_o,
  output logic                   lsu_is_load_o
);
  import addrgen_pkg::*;

  localparam int unsigned PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CntW = $clog2(QueueDepth + 1);

  addr_t     addr_mem [QueueDepth];
  beat_len_t len_mem [QueueDepth];
  size_t     size_mem [QueueDepth];
  logic      load_mem [QueueDepth];

  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            pop;

  assign lsu_valid_o = (count_q != '0);
  assign pop         = lsu_valid_o && lsu_ready_i;

  assign lsu_req.full         = (count_q == CntW'(QueueDepth));
  assign lsu_req.empty        = (count_q == '0);
  assign lsu_req.head_is_load = load_mem[rd_ptr_q];

  assign lsu_addr_o    = addr_mem[rd_ptr_q];
  assign lsu_len_o     = len_mem[rd_ptr_q];
  assign lsu_size_o    = size_mem[rd_ptr_q];
  assign lsu_is_load_o = load_mem[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (lsu_req.push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : wr_ptr_q + PtrW'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : rd_ptr_q + PtrW'(1);
      end
      count_q <= count_q + CntW'(lsu_req.push) - CntW'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (lsu_req.push) begin
      addr_mem[wr_ptr_q] <= lsu_req.addr;
      len_mem[wr_ptr_q]  <= lsu_req.len;
      size_mem[wr_ptr_q] <= lsu_req.size;
      load_mem[wr_ptr_q] <= lsu_req.is_load;
    end
  end

  // The controller must hold off while the queue is full
  assert property (@(posedge clk_i) disable iff (!rst_ni) lsu_req.push |-> !lsu_req.full);

endmodule

// ==== logic/addrgen_ctrl.sv ====
/*
  Address generator controller.
  Accepts one vector load or store, then issues AR or AW requests,
  one burst per cycle for unit stride or one element per cycle
  for strided access, and copies each request into the LSU queue.
*/
`timescale 1ns/1ps

module addrgen_ctrl #(
  parameter int unsigned BusBytesLog2 = 3
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Instruction
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  logic                  req_is_load_i,
  input  logic                  req_is_strided_i,
  input  addrgen_pkg::addr_t    req_base_addr_i,
  input  addrgen_pkg::stride_t  req_stride_i,
  input  addrgen_pkg::vl_t      req_vl_i,
  input  addrgen_pkg::sew_t     req_sew_i,
  // Read address channel
  output logic                  ar_valid_o,
  input  logic                  ar_ready_i,
  output addrgen_pkg::addr_t    ar_addr_o,
  output addrgen_pkg::beat_len_t ar_len_o,
  output addrgen_pkg::size_t    ar_size_o,
  // Write address channel
  output logic                  aw_valid_o,
  input  logic                  aw_ready_i,
  output addrgen_pkg::addr_t    aw_addr_o,
  output addrgen_pkg::beat_len_t aw_len_o,
  output addrgen_pkg::size_t    aw_size_o,
  burst_if.ctrl                 burst,
  lsu_req_if.ctrl               lsu_req
);
  import addrgen_pkg::*;

  ctrl_state_e state_q, state_d;

  logic      is_load_q;
  sew_t      sew_q;
  stride_t   stride_q;
  vl_t       vl_q;
  vl_t       elem_cnt_q;
  addr_t     cur_addr_q;
  bytes_t    rem_q;

  logic      accept;
  logic      dir_ok;
  logic      ax_ready;
  logic      issue;
  logic      last_elem;
  addr_t     req_addr;
  beat_len_t req_len;
  size_t     req_size;

  assign req_ready_o = (state_q == IDLE);
  assign accept      = req_valid_i && req_ready_o;

  assign burst.cur_addr  = cur_addr_q;
  assign burst.rem_bytes = rem_q;

  //////////////////////////////////////////////////////////////////////
  // Issue rule
  //////////////////////////////////////////////////////////////////////

  // Loads and stores never share the queue
  assign dir_ok    = lsu_req.empty || (lsu_req.head_is_load == is_load_q);
  assign ax_ready  = is_load_q ? ar_ready_i : aw_ready_i;
  assign issue     = (state_q != IDLE) && !lsu_req.full && dir_ok && ax_ready;
  assign last_elem = ({1'b0, elem_cnt_q} + 17'd1) >= {1'b0, vl_q};

  always_comb begin
    if (state_q == UNIT) begin
      req_addr = burst.start_addr;
      req_len  = burst.beats;
      req_size = size_t'(BusBytesLog2);
    end else begin
      req_addr = cur_addr_q;
      req_len  = '0;
      req_size = size_t'(sew_q);
    end
  end

  assign ar_valid_o = issue && is_load_q;
  assign ar_addr_o  = req_addr;
  assign ar_len_o   = req_len;
  assign ar_size_o  = req_size;
  assign aw_valid_o = issue && !is_load_q;
  assign aw_addr_o  = req_addr;
  assign aw_len_o   = req_len;
  assign aw_size_o  = req_size;

  assign lsu_req.push    = issue;
  assign lsu_req.addr    = req_addr;
  assign lsu_req.len     = req_len;
  assign lsu_req.size    = req_size;
  assign lsu_req.is_load = is_load_q;

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_valid_i) begin
          state_d = req_is_strided_i ? STRIDED : UNIT;
        end
      end
      UNIT: begin
        if (issue && (burst.next_rem == '0)) begin
          state_d = IDLE;
        end
      end
      STRIDED: begin
        if (issue && last_elem) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      elem_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        elem_cnt_q <= '0;
      end else if (issue && (state_q == STRIDED)) begin
        elem_cnt_q <= elem_cnt_q + vl_t'(1);
      end
    end
  end

  // Instruction payload and address stepping
  always_ff @(posedge clk_i) begin
    if (accept) begin
      is_load_q  <= req_is_load_i;
      sew_q      <= req_sew_i;
      stride_q   <= req_stride_i;
      vl_q       <= req_vl_i;
      cur_addr_q <= req_base_addr_i;
      rem_q      <= bytes_t'(req_vl_i) << req_sew_i;
    end else if (issue) begin
      if (state_q == UNIT) begin
        cur_addr_q <= burst.next_addr;
        rem_q      <= burst.next_rem;
      end else begin
        cur_addr_q <= cur_addr_q + stride_q;
      end
    end
  end

  // A unit-stride burst never runs past the end of its 4 KiB page
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (issue && (state_q == UNIT)) |->
      (32'(burst.start_addr[PageBits-1:0]) + ((32'(burst.beats) + 32'd1) << BusBytesLog2)
        <= (32'd1 << PageBits)));

endmodule

// ==== logic/addrgen_top.sv ====
/*
  Vector memory address generator top level.
  Joins the controller, burst planner and LSU address queue.
*/
`timescale 1ns/1ps

module addrgen_top #(
  parameter int unsigned BusBytesLog2 = 3,
  parameter int unsigned QueueDepth   = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Instruction
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  logic                   req_is_load_i,
  input  logic                   req_is_strided_i,
  input  addrgen_pkg::addr_t     req_base_addr_i,
  input  addrgen_pkg::stride_t   req_stride_i,
  input  addrgen_pkg::vl_t       req_vl_i,
  input  addrgen_pkg::sew_t      req_sew_i,
  // Read address channel
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output addrgen_pkg::addr_t     ar_addr_o,
  output addrgen_pkg::beat_len_t ar_len_o,
  output addrgen_pkg::size_t     ar_size_o,
  // Write address channel
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i,
  output addrgen_pkg::addr_t     aw_addr_o,
  output addrgen_pkg::beat_len_t aw_len_o,
  output addrgen_pkg::size_t     aw_size_o,
  // Load/store unit queue
  output logic                   lsu_valid_o,
  input  logic                   lsu_ready_i,
  output addrgen_pkg::addr_t     lsu_addr_o,
  output addrgen_pkg::beat_len_t lsu_len_o,
  output addrgen_pkg::size_t     lsu_size_o,
  output logic                   lsu_is_load_o
);

  burst_if   burst_if_i ();
  lsu_req_if lsu_req_if_i ();

  addrgen_ctrl #(
    .BusBytesLog2(BusBytesLog2)
  ) ctrl_i (
    .clk_i, .rst_ni,
    .req_valid_i, .req_ready_o, .req_is_load_i, .req_is_strided_i,
    .req_base_addr_i, .req_stride_i, .req_vl_i, .req_sew_i,
    .ar_valid_o, .ar_ready_i, .ar_addr_o, .ar_len_o, .ar_size_o,
    .aw_valid_o, .aw_ready_i, .aw_addr_o, .aw_len_o, .aw_size_o,
    .burst  (burst_if_i.ctrl),
    .lsu_req(lsu_req_if_i.ctrl)
  );

  burst_planner #(
    .BusBytesLog2(BusBytesLog2)
  ) planner_i (
    .burst(burst_if_i.planner)
  );

  addr_queue #(
    .QueueDepth(QueueDepth)
  ) queue_i (
    .clk_i, .rst_ni,
    .lsu_req(lsu_req_if_i.queue),
    .lsu_valid_o, .lsu_ready_i, .lsu_addr_o, .lsu_len_o, .lsu_size_o, .lsu_is_load_o
  );

endmodule

// ==== tb/tb_addrgen_top.sv ====
/*
  Directed testbench for the vector address generator.
  Reference model of the burst and stride rules, AX and LSU
  request monitors, directed test tasks, watchdog, error count.
*/
`timescale 1ns/1ps

module tb_addrgen_top;
  import addrgen_pkg::*;

  localparam int unsigned BusLog2        = 3;
  localparam int unsigned BusBytes       = 1 << BusLog2;
  localparam int unsigned ClkPeriod      = 100;
  // Longest sequence below needs well under a tenth of this
  localparam int unsigned WatchdogCycles = 2000;
  localparam logic [31:0] Seed           = 32'h58231450;

  // Request packed as {is_load, addr, len, size}
  typedef logic [43:0] entry_t;

  logic      clk_i;
  logic      rst_ni;
  logic      req_valid_i;
  logic      req_ready_o;
  logic      req_is_load_i;
  logic      req_is_strided_i;
  addr_t     req_base_addr_i;
  stride_t   req_stride_i;
  vl_t       req_vl_i;
  sew_t      req_sew_i;
  logic      ar_valid_o;
  logic      ar_ready_i;
  addr_t     ar_addr_o;
  beat_len_t ar_len_o;
  size_t     ar_size_o;
  logic      aw_valid_o;
  logic      aw_ready_i;
  addr_t     aw_addr_o;
  beat_len_t aw_len_o;
  size_t     aw_size_o;
  logic      lsu_valid_o;
  logic      lsu_ready_i;
  addr_t     lsu_addr_o;
  beat_len_t lsu_len_o;
  size_t     lsu_size_o;
  logic      lsu_is_load_o;

  entry_t exp_q[$];
  entry_t ax_q[$];
  entry_t lsu_q[$];
  int     errors;
  int     tests;
  logic   stall_en;

  addrgen_top #(
    .BusBytesLog2(BusLog2),
    .QueueDepth  (4)
  ) dut_i (
    .clk_i, .rst_ni,
    .req_valid_i, .req_ready_o, .req_is_load_i, .req_is_strided_i,
    .req_base_addr_i, .req_stride_i, .req_vl_i, .req_sew_i,
    .ar_valid_o, .ar_ready_i, .ar_addr_o, .ar_len_o, .ar_size_o,
    .aw_valid_o, .aw_ready_i, .aw_addr_o, .aw_len_o, .aw_size_o,
    .lsu_valid_o, .lsu_ready_i, .lsu_addr_o, .lsu_len_o, .lsu_size_o, .lsu_is_load_o
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // Outputs settle before the falling edge and handshakes complete on the next rise
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (ar_valid_o) begin
        ax_q.push_back({1'b1, ar_addr_o, ar_len_o, ar_size_o});
      end
      if (aw_valid_o) begin
        ax_q.push_back({1'b0, aw_addr_o, aw_len_o, aw_size_o});
      end
      if (lsu_valid_o && lsu_ready_i) begin
        lsu_q.push_back({lsu_is_load_o, lsu_addr_o, lsu_len_o, lsu_size_o});
      end
    end
  end

  // Random AR back-pressure while stalls are enabled
  initial begin
    logic en;
    int unsigned rnd;
    rnd = $urandom(Seed);
    ar_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      en  = stall_en;
      rnd = $urandom;
      #10;
      ar_ready_i = en ? ((rnd % 3) != 0) : 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  task automatic model_unit(input logic is_load, input addr_t base, input int unsigned bytes);
    int unsigned cur;
    int unsigned rem;
    int unsigned off;
    int unsigned start;
    int unsigned beats;
    int unsigned need;
    int unsigned covered;
    cur = base;
    rem = bytes;
    do begin
      off   = cur % BusBytes;
      start = cur - off;
      beats = (4096 - (start % 4096)) / BusBytes;
      if (beats > 256) begin
        beats = 256;
      end
      need = (rem + off + BusBytes - 1) / BusBytes;
      if (need < beats) begin
        beats = need;
      end
      exp_q.push_back({is_load, start, beat_len_t'(beats - 1), size_t'(BusLog2)});
      covered = beats * BusBytes - off;
      rem     = (rem > covered) ? rem - covered : 0;
      cur     = start + beats * BusBytes;
    end while (rem != 0);
  endtask

  task automatic model_strided(input logic is_load, input addr_t base, input stride_t stride,
                               input int unsigned vl, input sew_t sew);
    for (int unsigned i = 0; i < vl; i++) begin
      exp_q.push_back({is_load, base + addr_t'(i) * stride, 8'h00, {1'b0, sew}});
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Driving and checking
  //////////////////////////////////////////////////////////////////////

  task automatic start_test(input string name);
    exp_q.delete();
    ax_q.delete();
    lsu_q.delete();
    tests++;
    $display("Test %0d: %s", tests, name);
  endtask

  task automatic send_instr(input logic is_load, input logic strided, input addr_t base,
                            input stride_t stride, input vl_t vl, input sew_t sew);
    @(posedge clk_i);
    #10;
    req_valid_i      = 1'b1;
    req_is_load_i    = is_load;
    req_is_strided_i = strided;
    req_base_addr_i  = base;
    req_stride_i     = stride;
    req_vl_i         = vl;
    req_sew_i        = sew;
    @(posedge clk_i);
    #10;
    req_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    do begin
      @(negedge clk_i);
    end while (!req_ready_o);
  endtask

  task automatic drain_lsu();
    while (lsu_valid_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #10;
  endtask

  task automatic compare_reqs(input logic from_lsu);
    string  name;
    int     n;
    entry_t got;
    name = from_lsu ? "lsu_req" : "ax_req";
    n    = from_lsu ? lsu_q.size() : ax_q.size();
    if (n != exp_q.size()) begin
      errors++;
      $display("Fail %s count: got 0x%h, expected 0x%h", name, n, exp_q.size());
    end
    for (int i = 0; i < n && i < exp_q.size(); i++) begin
      got = from_lsu ? lsu_q[i] : ax_q[i];
      if (got != exp_q[i]) begin
        errors++;
        $display("Fail %s[%0d]: got load=%h addr=%h len=%h size=%h", name, i,
                 got[43], got[42:11], got[10:3], got[2:0]);
        $display("  expected load=%h addr=%h len=%h size=%h",
                 exp_q[i][43], exp_q[i][42:11], exp_q[i][10:3], exp_q[i][2:0]);
      end
    end
  endtask

  task automatic check_reset_state();
    if (ar_valid_o || aw_valid_o || lsu_valid_o || !req_ready_o) begin
      errors++;
      $display("Fail reset state: ar/aw/lsu valid = %h/%h/%h, req_ready_o = %h",
               ar_valid_o, aw_valid_o, lsu_valid_o, req_ready_o);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_single_burst();
    start_test("unit-stride load inside one page");
    exp_q.push_back({1'b1, 32'h1000_0100, 8'd15, 3'd3});
    send_instr(1'b1, 1'b0, 32'h1000_0100, '0, 16'd16, 2'd3);
    wait_idle();
    drain_lsu();
    compare_reqs(1'b0);
    compare_reqs(1'b1);
  endtask

  task automatic test_page_split();
    start_test("unit-stride store across a page end");
    exp_q.push_back({1'b0, 32'h0000_2FC0, 8'd7, 3'd3});
    exp_q.push_back({1'b0, 32'h0000_3000, 8'd23, 3'd3});
    send_instr(1'b0, 1'b0, 32'h0000_2FC0, '0, 16'd32, 2'd3);
    wait_idle();
    drain_lsu();
    compare_reqs(1'b0);
    compare_reqs(1'b1);
  endtask

  task automatic test_long_load();
    addr_t       a;
    int unsigned beats;
    int unsigned total;
    start_test("long unit-stride load");
    model_unit(1'b1, 32'h0001_0000, 2100 * 8);
    send_instr(1'b1, 1'b0, 32'h0001_0000, '0, 16'd2100, 2'd3);
    wait_idle();
    drain_lsu();
    compare_reqs(1'b0);
    compare_reqs(1'b1);
    total = 0;
    foreach (ax_q[i]) begin
      a     = ax_q[i][42:11];
      beats = int'(ax_q[i][10:3]) + 1;
      if ((a % 4096) + beats * BusBytes > 4096) begin
        errors++;
        $display("Burst %0d at 0x%h runs past its 4 KiB page", i, a);
      end
      total += beats;
    end
    if (total * BusBytes < 2100 * 8) begin
      errors++;
      $display("Fail ax_beats: got 0x%h, expected at least 0x%h", total, 2100);
    end
  endtask

  task automatic test_strided();
    start_test("strided load");
    model_strided(1'b1, 32'h8000_0FF0, 32'd24, 5, 2'd2);
    send_instr(1'b1, 1'b1, 32'h8000_0FF0, 32'd24, 16'd5, 2'd2);
    wait_idle();
    drain_lsu();
    compare_reqs(1'b0);
    compare_reqs(1'b1);
  endtask

  task automatic test_ar_stalls();
    start_test("random AR back-pressure");
    stall_en = 1'b1;
    model_unit(1'b1, 32'h0000_5F80, 64 * 8);
    model_strided(1'b1, 32'h0000_9000, 32'hFFFF_FFF0, 8, 2'd3);
    send_instr(1'b1, 1'b0, 32'h0000_5F80, '0, 16'd64, 2'd3);
    wait_idle();
    send_instr(1'b1, 1'b1, 32'h0000_9000, 32'hFFFF_FFF0, 16'd8, 2'd3);
    wait_idle();
    stall_en = 1'b0;
    drain_lsu();
    compare_reqs(1'b0);
    compare_reqs(1'b1);
  endtask

  task automatic test_direction_order();
    start_test("store held behind queued loads");
    lsu_ready_i = 1'b0;
    model_strided(1'b1, 32'h0000_7000, 32'd64, 3, 2'd2);
    model_unit(1'b0, 32'h0000_8000, 4 * 8);
    send_instr(1'b1, 1'b1, 32'h0000_7000, 32'd64, 16'd3, 2'd2);
    wait_idle();
    send_instr(1'b0, 1'b0, 32'h0000_8000, '0, 16'd4, 2'd3);
    repeat (10) begin
      @(negedge clk_i);
      if (aw_valid_o) begin
        errors++;
        $display("A store address was issued while loads were still queued");
      end
    end
    @(posedge clk_i);
    #10;
    lsu_ready_i = 1'b1;
    wait_idle();
    drain_lsu();
    compare_reqs(1'b0);
    compare_reqs(1'b1);
  endtask

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Timeout after %0d clock periods, the DUT stopped responding", WatchdogCycles);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    req_valid_i      = 1'b0;
    req_is_load_i    = 1'b0;
    req_is_strided_i = 1'b0;
    req_base_addr_i  = '0;
    req_stride_i     = '0;
    req_vl_i         = '0;
    req_sew_i        = '0;
    aw_ready_i       = 1'b1;
    lsu_ready_i      = 1'b1;
    stall_en         = 1'b0;
    errors           = 0;
    tests            = 0;
    repeat (8) @(posedge clk_i);
    #10;
    check_reset_state();
    rst_ni = 1'b1;

    test_single_burst();
    test_page_split();
    test_long_load();
    test_strided();
    test_ar_stalls();
    test_direction_order();

    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== addrgen_top.f ====
logic/addrgen_pkg.sv
logic/burst_if.sv
logic/lsu_req_if.sv
logic/burst_planner.sv
logic/addr_queue.sv
logic/addrgen_ctrl.sv
logic/addrgen_top.sv
tb/tb_addrgen_top.sv

// ==== Makefile ====
TOP   = tb_addrgen_top
FLIST = addrgen_top.f

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f $(FLIST) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
